// ==== Makefile ====
# Verilator build for the peripheral subsystem testbench.
VERILATOR ?= verilator
VFLAGS    = --timing --assert
TOP       = soc_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
PASS_MSG  = Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
+incdir+.
soc_pkg.sv
bus_decode.sv
word_ram.sv
interval_timer.sv
seg_display.sv
soc_top.sv
soc_tb.sv

// ==== bus_decode.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "soc_consts.svh"

module bus_decode
(
  input  wire                   clk_i,
  input  wire                   rst_n_i,
  input  wire soc_pkg::wb_req_t m_req_i,
  output soc_pkg::wb_rsp_t      m_rsp_o,
  output soc_pkg::wb_req_t      ram_req_o,
  output soc_pkg::wb_req_t      tmr_req_o,
  output soc_pkg::wb_req_t      seg_req_o,
  input  wire soc_pkg::wb_rsp_t ram_rsp_i,
  input  wire soc_pkg::wb_rsp_t tmr_rsp_i,
  input  wire soc_pkg::wb_rsp_t seg_rsp_i
);

  soc_pkg::target_e tgt;
  soc_pkg::target_e tgt_q;
  logic             accept;
  logic             err_pend_q;

  assign accept = m_req_i.cyc & m_req_i.stb;  // never stalls.

  // ##################################################
  // request side
  always_comb
  begin
    tgt = soc_pkg::TGT_NONE;
    if (m_req_i.adr[31:28] == `SOC_RAM_REGION)
    begin
      tgt = soc_pkg::TGT_RAM;
    end
    else if (m_req_i.adr[31:28] == `SOC_IO_REGION)
    begin
      case (m_req_i.adr[15:12])
        `SOC_TIMER_SUB: tgt = soc_pkg::TGT_TIMER;
        `SOC_SEG_SUB:   tgt = soc_pkg::TGT_SEG;
        default:        tgt = soc_pkg::TGT_NONE;
      endcase
    end
  end

  always_comb
  begin
    ram_req_o     = m_req_i;
    tmr_req_o     = m_req_i;
    seg_req_o     = m_req_i;
    ram_req_o.stb = m_req_i.stb & (tgt == soc_pkg::TGT_RAM);
    tmr_req_o.stb = m_req_i.stb & (tgt == soc_pkg::TGT_TIMER);
    seg_req_o.stb = m_req_i.stb & (tgt == soc_pkg::TGT_SEG);
  end

  // ##################################################
  // response side
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      tgt_q      <= soc_pkg::TGT_NONE;
      err_pend_q <= 1'b0;
    end
    else
    begin
      err_pend_q <= accept & (tgt == soc_pkg::TGT_NONE);
      if (accept)
      begin
        tgt_q <= tgt;
      end
    end
  end

  always_comb
  begin
    case (tgt_q)
      soc_pkg::TGT_RAM:   m_rsp_o = ram_rsp_i;
      soc_pkg::TGT_TIMER: m_rsp_o = tmr_rsp_i;
      soc_pkg::TGT_SEG:   m_rsp_o = seg_rsp_i;
      default:            m_rsp_o = '{ack: 1'b0, err: err_pend_q, stall: 1'b0, dat: 32'h0};
    endcase
  end

endmodule

`default_nettype wire

// ==== interval_timer.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "soc_consts.svh"

module interval_timer
(
  input  wire                   clk_i,
  input  wire                   rst_n_i,
  input  wire soc_pkg::wb_req_t req_i,
  output soc_pkg::wb_rsp_t      rsp_o,
  output logic                  irq_o
);

  soc_pkg::tmr_mode_e mode_q;
  logic               en_q;
  logic               ie_q;
  logic               pend_q;
  logic [31:0]        cmp_q;
  logic [31:0]        count_q;
  logic               accept;
  logic               wr;
  logic               hit;
  logic [3:0]         reg_off;
  logic [31:0]        rd_dat;
  logic               ack_q;
  logic [31:0]        dat_q;

  assign accept  = req_i.cyc & req_i.stb;
  assign wr      = accept & req_i.we;
  assign reg_off = {req_i.adr[3:2], 2'b00};
  assign hit     = en_q & (count_q == cmp_q);
  assign irq_o   = pend_q & ie_q;

  // ##################################################
  // counter and registers
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      en_q    <= 1'b0;
      mode_q  <= soc_pkg::TMR_ONESHOT;
      ie_q    <= 1'b0;
      pend_q  <= 1'b0;
      cmp_q   <= 32'h0;
      count_q <= 32'h0;
    end
    else
    begin
      if (hit)
      begin
        count_q <= 32'h0;
        pend_q  <= 1'b1;
        if (mode_q == soc_pkg::TMR_ONESHOT)
        begin
          en_q <= 1'b0;
        end
      end
      else if (en_q)
      begin
        count_q <= count_q + 32'h1;
      end
      if (wr && reg_off == `TMR_STAT && req_i.dat[0] && !hit)
      begin
        pend_q <= 1'b0;  // a new hit wins.
      end
      if (wr && reg_off == `TMR_CTRL)
      begin
        en_q   <= req_i.dat[0];
        mode_q <= soc_pkg::tmr_mode_e'(req_i.dat[1]);
        ie_q   <= req_i.dat[2];
      end
      if (wr && reg_off == `TMR_CMP)
      begin
        cmp_q <= req_i.dat;
      end
    end
  end

  always_comb
  begin
    case (reg_off)
      `TMR_CTRL:  rd_dat = {29'h0, ie_q, mode_q, en_q};
      `TMR_CMP:   rd_dat = cmp_q;
      `TMR_COUNT: rd_dat = count_q;
      default:    rd_dat = {31'h0, pend_q};
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      ack_q <= 1'b0;
    end
    else
    begin
      ack_q <= accept;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      dat_q <= rd_dat;
    end
  end

  assign rsp_o = '{ack: ack_q, err: 1'b0, stall: 1'b0, dat: dat_q};

endmodule

`default_nettype wire

// ==== seg_display.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "soc_consts.svh"

module seg_display
(
  input  wire                   clk_i,
  input  wire                   rst_n_i,
  input  wire soc_pkg::wb_req_t req_i,
  output soc_pkg::wb_rsp_t      rsp_o,
  output soc_pkg::seg_bank_t    hex_o
);

  logic [31:0]                value_q;
  logic [`SOC_SEG_DIGITS-1:0] dots_q;
  logic                       accept;
  logic                       wr;
  logic [3:0]                 reg_off;
  logic                       ack_q;
  logic [31:0]                dat_q;

  assign accept  = req_i.cyc & req_i.stb;
  assign wr      = accept & req_i.we;
  assign reg_off = {req_i.adr[3:2], 2'b00};

  // active low hex glyph as g..a.
  function automatic logic [6:0] glyph(input logic [3:0] nib);
    logic [6:0] segs;
    case (nib)
      4'h0: segs = 7'h40;
      4'h1: segs = 7'h79;
      4'h2: segs = 7'h24;
      4'h3: segs = 7'h30;
      4'h4: segs = 7'h19;
      4'h5: segs = 7'h12;
      4'h6: segs = 7'h02;
      4'h7: segs = 7'h78;
      4'h8: segs = 7'h00;
      4'h9: segs = 7'h10;
      4'ha: segs = 7'h08;
      4'hb: segs = 7'h03;
      4'hc: segs = 7'h46;
      4'hd: segs = 7'h21;
      4'he: segs = 7'h06;
      default: segs = 7'h0e;
    endcase
    return segs;
  endfunction

  always_comb
  begin
    for (int k = 0; k < `SOC_SEG_DIGITS; k++)
    begin
      hex_o[k] = {~dots_q[k], glyph(value_q[k*4 +: 4])};
    end
  end

  // ##################################################
  // register interface
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      value_q <= 32'h0;
      dots_q  <= '0;
      ack_q   <= 1'b0;
    end
    else
    begin
      ack_q <= accept;
      if (wr && reg_off == `SEG_VALUE)
      begin
        for (int b = 0; b < 4; b++)
        begin
          if (req_i.sel[b])
          begin
            value_q[b*8 +: 8] <= req_i.dat[b*8 +: 8];
          end
        end
      end
      if (wr && reg_off == `SEG_DOTS && req_i.sel[0])
      begin
        dots_q <= req_i.dat[`SOC_SEG_DIGITS-1:0];
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      case (reg_off)
        `SEG_VALUE: dat_q <= value_q;
        `SEG_DOTS:  dat_q <= {{(32-`SOC_SEG_DIGITS){1'b0}}, dots_q};
        default:    dat_q <= 32'h0;
      endcase
    end
  end

  assign rsp_o = '{ack: ack_q, err: 1'b0, stall: 1'b0, dat: dat_q};

endmodule

`default_nettype wire

// ==== soc_consts.svh ====
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// ##################################################
// bits 31:28 pick the region.
`define SOC_RAM_REGION  4'h0
`define SOC_IO_REGION   4'h3
`define SOC_SEG_SUB     4'h0  // io bits 15:12.
`define SOC_TIMER_SUB   4'h8

`define SOC_RAM_AWIDTH  10    // word address bits.
`define SOC_SEG_DIGITS  8

// timer registers.
`define TMR_CTRL        4'h0
`define TMR_CMP         4'h4
`define TMR_COUNT       4'h8
`define TMR_STAT        4'hc

`define SEG_VALUE       4'h0
`define SEG_DOTS        4'h4

`endif

// ==== soc_pkg.sv ====
`default_nettype none

`include "soc_consts.svh"

package soc_pkg;

  // one master request in wishbone pipelined style.
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [3:0]  sel;
    logic [31:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic        err;
    logic        stall;
    logic [31:0] dat;
  } wb_rsp_t;

  // active low point in bit 7 and g..a in 6:0.
  typedef logic [`SOC_SEG_DIGITS-1:0][7:0] seg_bank_t;

  typedef enum logic [1:0] {
    TGT_RAM,
    TGT_TIMER,
    TGT_SEG,
    TGT_NONE
  } target_e;

  typedef enum logic {
    TMR_ONESHOT,
    TMR_PERIODIC
  } tmr_mode_e;

endpackage

`default_nettype wire

// ==== soc_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "soc_consts.svh"

module soc_tb;

  localparam int LIMIT = 200;  // cycles per wait.
  localparam logic [31:0] SEG_BASE = {`SOC_IO_REGION, 12'h000, `SOC_SEG_SUB, 12'h000};
  localparam logic [31:0] TMR_BASE = {`SOC_IO_REGION, 12'h000, `SOC_TIMER_SUB, 12'h000};

  logic               clk;
  logic               rst_n;
  soc_pkg::wb_req_t   req;
  soc_pkg::wb_rsp_t   rsp;
  soc_pkg::seg_bank_t hex;
  logic               irq;
  integer             seed;
  logic [31:0]        ram_model [2**`SOC_RAM_AWIDTH];
  bit                 ram_known [2**`SOC_RAM_AWIDTH];
  logic [31:0]        adrs [8];
  // lit segments g..a for each hex digit.
  logic [6:0]         lit_segs [16] = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
                                        7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};

  soc_top dut0(.clk_i(clk), .rst_n_i(rst_n), .wb_req_i(req), .wb_rsp_o(rsp),
               .hex_o(hex), .irq_o(irq));

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ##################################################
  // checks and bus tasks
  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else report_error($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                                $time, what, got, exp));
  endtask

  // one request then a wait for ack or err.
  task automatic bus_access(input logic we, input logic [31:0] adr, input logic [3:0] sel,
                            input logic [31:0] dat, output soc_pkg::wb_rsp_t got);
    int n;
    n = 0;
    @(posedge clk);
    req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, sel: sel, dat: dat};
    @(posedge clk);
    req <= '0;
    @(negedge clk);
    while (!(rsp.ack || rsp.err))
    begin
      if (n == LIMIT)
      begin
        report_error("timeout waiting for a bus ack or err");
      end
      else
      begin
        n++;
        @(negedge clk);
      end
    end
    got = rsp;
    check_value("bus stall", {31'h0, got.stall}, 32'h0);
  endtask

  task automatic reg_write(input logic [31:0] adr, input logic [31:0] dat);
    soc_pkg::wb_rsp_t got;
    bus_access(1'b1, adr, 4'hf, dat, got);
    check_value("write ack", {31'h0, got.ack}, 32'h1);
  endtask

  task automatic reg_read(input string what, input logic [31:0] adr, input logic [31:0] exp);
    soc_pkg::wb_rsp_t got;
    bus_access(1'b0, adr, 4'hf, 32'h0, got);
    check_value({what, " ack"}, {31'h0, got.ack}, 32'h1);
    check_value(what, got.dat, exp);
  endtask

  task automatic ram_write(input logic [31:0] adr, input logic [3:0] sel, input logic [31:0] dat);
    soc_pkg::wb_rsp_t           got;
    logic [`SOC_RAM_AWIDTH-1:0] idx;
    idx = adr[`SOC_RAM_AWIDTH+1:2];
    bus_access(1'b1, adr, sel, dat, got);
    check_value("ram write ack", {31'h0, got.ack}, 32'h1);
    if (ram_known[idx])
    begin
      check_value("ram old word", got.dat, ram_model[idx]);  // write returns old data.
    end
    for (int b = 0; b < 4; b++)
    begin
      if (sel[b])
      begin
        ram_model[idx][b*8 +: 8] = dat[b*8 +: 8];
      end
    end
    ram_known[idx] = 1'b1;
  endtask

  task automatic check_unmapped(input logic we, input logic [31:0] adr);
    soc_pkg::wb_rsp_t got;
    bus_access(we, adr, 4'hf, 32'hdead_beef, got);
    check_value("unmapped err", {31'h0, got.err}, 32'h1);
    check_value("unmapped ack", {31'h0, got.ack}, 32'h0);
    check_value("unmapped data", got.dat, 32'h0);
  endtask

  task automatic check_display(input logic [31:0] value, input logic [7:0] dots);
    for (int k = 0; k < `SOC_SEG_DIGITS; k++)
    begin
      check_value($sformatf("digit %0d", k), {24'h0, hex[k]},
                  {24'h0, ~dots[k], ~lit_segs[value[k*4 +: 4]]});
    end
  endtask

  task automatic wait_irq();
    int n;
    n = 0;
    @(negedge clk);
    while (!irq)
    begin
      if (n == LIMIT)
      begin
        report_error("timeout waiting for the timer interrupt");
      end
      else
      begin
        n++;
        @(negedge clk);
      end
    end
  endtask

  // ##################################################
  // stimulus
  initial
  begin
    logic [31:0] r;
    logic [31:0] s;
    logic [31:0] value;
    seed  = 32'h65f8b167;
    req   = '0;
    rst_n = 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("ack after reset", {31'h0, rsp.ack}, 32'h0);
    check_value("irq after reset", {31'h0, irq}, 32'h0);
    check_display(32'h0, 8'h0);

    for (int i = 0; i < 8; i++)
    begin
      r       = $random(seed);
      adrs[i] = {4'h0, r[27:2], 2'b00};  // upper bits alias onto the ram.
      r       = $random(seed);
      ram_write(adrs[i], 4'hf, r);
      r = $random(seed);
      s = $random(seed);
      ram_write(adrs[i], s[3:0], r);
    end
    for (int i = 0; i < 8; i++)
    begin
      reg_read("ram word", adrs[i], ram_model[adrs[i][`SOC_RAM_AWIDTH+1:2]]);
    end

    check_unmapped(1'b0, 32'h5000_0010);
    check_unmapped(1'b1, {`SOC_IO_REGION, 12'h000, 4'h4, 12'h000});
    reg_read("ram after error", adrs[0], ram_model[adrs[0][`SOC_RAM_AWIDTH+1:2]]);

    // four reads back to back with one ack each.
    @(posedge clk);
    req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adrs[0], sel: 4'hf, dat: 32'h0};
    for (int i = 0; i < 4; i++)
    begin
      @(posedge clk);
      if (i < 3)
      begin
        req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adrs[i+1], sel: 4'hf, dat: 32'h0};
      end
      else
      begin
        req <= '0;
      end
      @(negedge clk);
      check_value("burst ack", {31'h0, rsp.ack}, 32'h1);
      check_value("burst data", rsp.dat, ram_model[adrs[i][`SOC_RAM_AWIDTH+1:2]]);
    end
    @(negedge clk);
    check_value("ack after burst", {31'h0, rsp.ack}, 32'h0);

    value = $random(seed);
    r     = $random(seed);
    reg_write({SEG_BASE[31:4], `SEG_VALUE}, value);
    reg_write({SEG_BASE[31:4], `SEG_DOTS}, {24'h0, r[7:0]});
    check_display(value, r[7:0]);
    reg_read("seg value", {SEG_BASE[31:4], `SEG_VALUE}, value);
    reg_read("seg dots", {SEG_BASE[31:4], `SEG_DOTS}, {24'h0, r[7:0]});

    // ##################################################
    // one-shot timer then periodic mode
    reg_write({TMR_BASE[31:4], `TMR_CMP}, 32'd20);
    reg_write({TMR_BASE[31:4], `TMR_CTRL}, 32'h5);
    wait_irq();
    reg_read("ctrl after one-shot", {TMR_BASE[31:4], `TMR_CTRL}, 32'h4);
    reg_write({TMR_BASE[31:4], `TMR_STAT}, 32'h1);
    check_value("irq after clear", {31'h0, irq}, 32'h0);
    reg_write({TMR_BASE[31:4], `TMR_CTRL}, 32'h7);
    wait_irq();
    reg_write({TMR_BASE[31:4], `TMR_STAT}, 32'h1);
    check_value("irq after periodic clear", {31'h0, irq}, 32'h0);
    wait_irq();
    reg_read("ctrl in periodic", {TMR_BASE[31:4], `TMR_CTRL}, 32'h7);

    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== soc_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module soc_top
(
  input  wire                   clk_i,
  input  wire                   rst_n_i,
  input  wire soc_pkg::wb_req_t wb_req_i,
  output soc_pkg::wb_rsp_t      wb_rsp_o,
  output soc_pkg::seg_bank_t    hex_o,
  output logic                  irq_o
);

  soc_pkg::wb_req_t ram_req;
  soc_pkg::wb_req_t tmr_req;
  soc_pkg::wb_req_t seg_req;
  soc_pkg::wb_rsp_t ram_rsp;
  soc_pkg::wb_rsp_t tmr_rsp;
  soc_pkg::wb_rsp_t seg_rsp;

  // ##################################################
  // master side decode
  bus_decode decode0(.clk_i(clk_i), .rst_n_i(rst_n_i),
                     .m_req_i(wb_req_i),
                     .m_rsp_o(wb_rsp_o),
                     .ram_req_o(ram_req),
                     .tmr_req_o(tmr_req),
                     .seg_req_o(seg_req),
                     .ram_rsp_i(ram_rsp),
                     .tmr_rsp_i(tmr_rsp),
                     .seg_rsp_i(seg_rsp));

  // ##################################################
  // targets
  word_ram ram0(.clk_i(clk_i), .rst_n_i(rst_n_i),
                .req_i(ram_req),
                .rsp_o(ram_rsp));

  interval_timer timer0(.clk_i(clk_i), .rst_n_i(rst_n_i),
                        .req_i(tmr_req),
                        .rsp_o(tmr_rsp),
                        .irq_o(irq_o));

  seg_display seg0(.clk_i(clk_i), .rst_n_i(rst_n_i),
                   .req_i(seg_req),
                   .rsp_o(seg_rsp),
                   .hex_o(hex_o));

endmodule

`default_nettype wire

// ==== word_ram.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "soc_consts.svh"

module word_ram
#(
  parameter int AWIDTH = `SOC_RAM_AWIDTH
)
(
  input  wire                   clk_i,
  input  wire                   rst_n_i,
  input  wire soc_pkg::wb_req_t req_i,
  output soc_pkg::wb_rsp_t      rsp_o
);

  logic [31:0]       mem [2**AWIDTH];
  logic [AWIDTH-1:0] word_adr;
  logic              accept;
  logic              ack_q;
  logic [31:0]       dat_q;

  assign word_adr = req_i.adr[AWIDTH+1:2];  // upper bits alias.
  assign accept   = req_i.cyc & req_i.stb;

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      dat_q <= mem[word_adr];  // old word on a write.
      if (req_i.we)
      begin
        for (int b = 0; b < 4; b++)
        begin
          if (req_i.sel[b])
          begin
            mem[word_adr][b*8 +: 8] <= req_i.dat[b*8 +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      ack_q <= 1'b0;
    end
    else
    begin
      ack_q <= accept;
    end
  end

  assign rsp_o = '{ack: ack_q, err: 1'b0, stall: 1'b0, dat: dat_q};

endmodule

`default_nettype wire
